//--- hdl/ccl_macros.svh
// image size and table capacities for the labeling core, included by the package and RTL
`ifndef CCL_MACROS_SVH
`define CCL_MACROS_SVH

// frame geometry
`define CCL_IMG_W      16
`define CCL_IMG_H      16

// checkerboard worst case plus background label 0
`define CCL_MAX_LABELS ((`CCL_IMG_W * `CCL_IMG_H) / 2 + 1)
`define CCL_MAX_PAIRS  (`CCL_IMG_W * `CCL_IMG_H)

// derived widths
`define CCL_X_W        $clog2(`CCL_IMG_W)
`define CCL_Y_W        $clog2(`CCL_IMG_H)
`define CCL_LABEL_W    $clog2(`CCL_MAX_LABELS)
`define CCL_AREA_W     $clog2(`CCL_IMG_W * `CCL_IMG_H + 1)
`define CCL_PAIR_W     $clog2(`CCL_MAX_PAIRS)

`endif

//--- hdl/ccl_pkg.sv
// shared types of the labeling core, taken by wildcard import in each module header
package ccl_pkg;

`include "ccl_macros.svh"

typedef logic [`CCL_LABEL_W-1:0] label_t;    // 0 is background
typedef logic [`CCL_X_W-1:0]     xcoord_t;
typedef logic [`CCL_Y_W-1:0]     ycoord_t;
typedef logic [`CCL_AREA_W-1:0]  area_t;

// walk of the second pass
typedef enum logic [2:0] {
    rp_idle,
    rp_wait_resolve,
    rp_fold,
    rp_emit,
    rp_done
} report_phase_t;

endpackage

//--- hdl/ccl_ifs.sv
// bundles between the labeling stages, instantiated once each in the top level
`timescale 1ns/1ps

interface pix_if import ccl_pkg::*; ();
    logic    pix_valid;      // href one cycle late
    logic    pix;
    xcoord_t x;
    ycoord_t y;
    logic    frame_start;
    logic    frame_end;

    modport src (output pix_valid, pix, x, y, frame_start, frame_end);
    modport dst (input  pix_valid, pix, x, y, frame_start, frame_end);
endinterface

interface feature_if import ccl_pkg::*; ();
    // pixel update from the first pass
    logic    upd_valid;
    label_t  upd_label;
    xcoord_t upd_x;
    ycoord_t upd_y;
    // add src into dst
    logic    merge_valid;
    label_t  merge_src;
    label_t  merge_dst;
    // combinational read port
    label_t  rd_label;
    area_t   rd_area;
    xcoord_t rd_xmin;
    xcoord_t rd_xmax;
    ycoord_t rd_ymin;
    ycoord_t rd_ymax;

    modport pix_wr (output upd_valid, upd_label, upd_x, upd_y);
    modport store (
        input  upd_valid, upd_label, upd_x, upd_y,
        input  merge_valid, merge_src, merge_dst, rd_label,
        output rd_area, rd_xmin, rd_xmax, rd_ymin, rd_ymax
    );
    modport merge_rd (
        output merge_valid, merge_src, merge_dst, rd_label,
        input  rd_area, rd_xmin, rd_xmax, rd_ymin, rd_ymax
    );
endinterface

interface equiv_if import ccl_pkg::*; ();
    logic   push_valid;
    label_t push_hi;
    label_t push_lo;
    logic   resolve_start;
    label_t q_label;
    logic   resolved;
    label_t q_root;

    modport push (output push_valid, push_hi, push_lo);
    modport tbl (
        input  push_valid, push_hi, push_lo, resolve_start, q_label,
        output resolved, q_root
    );
    modport query (output resolve_start, q_label, input resolved, q_root);
endinterface

//--- hdl/pixel_frontend.sv
// input stage of the labeling core, registers the video signals and tracks x and y
`timescale 1ns/1ps

module pixel_frontend import ccl_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic vsync_i,
    input  logic href_i,
    input  logic pix_i,
    input  logic busy_i,        // report of the last frame still running
    pix_if.src   pix_o
);
    logic    vsync_q;
    logic    href_q;
    logic    skip_q;            // frame began while busy
    logic    vs_rise;
    logic    vs_fall;
    xcoord_t x_q;
    ycoord_t y_q;

    assign vs_rise = vsync_i & ~vsync_q;
    assign vs_fall = ~vsync_i & vsync_q;
    assign pix_o.x = x_q;
    assign pix_o.y = y_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vsync_q           <= 1'b0;
            href_q            <= 1'b0;
            skip_q            <= 1'b0;
            x_q               <= '0;
            y_q               <= '0;
            pix_o.pix_valid   <= 1'b0;
            pix_o.frame_start <= 1'b0;
            pix_o.frame_end   <= 1'b0;
        end else begin
            vsync_q <= vsync_i;
            href_q  <= href_i;
            if (vs_rise)
                skip_q <= busy_i;
            if (href_i)
                x_q <= href_q ? x_q + 1'b1 : '0;   // restart on href rise
            if (vs_rise)
                y_q <= '0;
            else if (href_q && !href_i)
                y_q <= y_q + 1'b1;                  // next row on href fall
            pix_o.pix_valid   <= href_i & ~busy_i & ~skip_q;
            pix_o.frame_start <= vs_rise & ~busy_i;
            pix_o.frame_end   <= vs_fall & ~skip_q;
        end
    end

    always_ff @(posedge clk) begin
        pix_o.pix <= pix_i;
    end

endmodule

//--- hdl/label_assign.sv
// first pass, gives each foreground pixel a provisional label and queues touching labels
`timescale 1ns/1ps
`include "ccl_macros.svh"

module label_assign import ccl_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    pix_if.dst        pix_i,
    feature_if.pix_wr feat_o,
    equiv_if.push     eq_o
);
    label_t line_buf [`CCL_IMG_W];   // labels of the row above
    label_t left_q;
    label_t cnt_q;                   // highest label issued so far
    label_t up_lbl;
    label_t left_lbl;
    label_t new_lbl;
    logic   fg;
    logic   both_set;

    assign fg       = pix_i.pix_valid & pix_i.pix;
    assign up_lbl   = (pix_i.y == '0) ? '0 : line_buf[pix_i.x];
    assign left_lbl = (pix_i.x == '0) ? '0 : left_q;
    assign both_set = (up_lbl != '0) && (left_lbl != '0);

    always_comb begin
        if (!pix_i.pix)
            new_lbl = '0;
        else if (up_lbl == '0 && left_lbl == '0)
            new_lbl = cnt_q + 1'b1;            // new component
        else if (up_lbl == '0)
            new_lbl = left_lbl;
        else if (left_lbl == '0)
            new_lbl = up_lbl;
        else
            new_lbl = (left_lbl < up_lbl) ? left_lbl : up_lbl;
    end

    // read at x above, then overwritten with this row
    always_ff @(posedge clk) begin
        if (pix_i.pix_valid) begin
            line_buf[pix_i.x] <= new_lbl;
            left_q            <= new_lbl;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q           <= '0;
            feat_o.upd_valid <= 1'b0;
            eq_o.push_valid  <= 1'b0;
        end else begin
            if (pix_i.frame_start)
                cnt_q <= '0;
            else if (fg && up_lbl == '0 && left_lbl == '0)
                cnt_q <= new_lbl;
            feat_o.upd_valid <= fg;
            eq_o.push_valid  <= fg && both_set && (up_lbl != left_lbl);
        end
    end

    always_ff @(posedge clk) begin
        feat_o.upd_label <= new_lbl;
        feat_o.upd_x     <= pix_i.x;
        feat_o.upd_y     <= pix_i.y;
        eq_o.push_hi     <= (left_lbl < up_lbl) ? up_lbl : left_lbl;
        eq_o.push_lo     <= new_lbl;              // smaller of the two
    end

    // issued labels stay inside the label tables of both stores
    a_label_cap: assert property (@(posedge clk) disable iff (rst)
        cnt_q < `CCL_MAX_LABELS);

endmodule

//--- hdl/equiv_table.sv
// union-find over the label pairs of one frame, resolved to flat roots after the frame ends
`timescale 1ns/1ps
`include "ccl_macros.svh"

module equiv_table import ccl_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic frame_start_i,
    equiv_if.tbl eq_i
);
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_load = 2'd1;
    localparam logic [1:0] st_find = 2'd2;
    localparam logic [1:0] st_flat = 2'd3;

    label_t                 parent  [`CCL_MAX_LABELS];
    label_t                 pair_hi [`CCL_MAX_PAIRS];
    label_t                 pair_lo [`CCL_MAX_PAIRS];
    logic [`CCL_PAIR_W-1:0] wr_ptr;
    logic [`CCL_PAIR_W-1:0] rd_ptr;
    logic [1:0]             state;
    label_t                 a_q;
    label_t                 b_q;
    label_t                 idx_q;      // flatten position
    logic                   resolved_q;
    logic                   roots_found;
    label_t                 lo_root;
    label_t                 hi_root;

    assign roots_found   = (parent[a_q] == a_q) && (parent[b_q] == b_q);
    assign lo_root       = (a_q < b_q) ? a_q : b_q;
    assign hi_root       = (a_q < b_q) ? b_q : a_q;
    assign eq_i.q_root   = parent[eq_i.q_label];
    assign eq_i.resolved = resolved_q;

    always_ff @(posedge clk) begin
        if (eq_i.push_valid) begin
            pair_hi[wr_ptr] <= eq_i.push_hi;
            pair_lo[wr_ptr] <= eq_i.push_lo;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start_i) begin
            for (int i = 0; i < `CCL_MAX_LABELS; i++)
                parent[i] <= label_t'(i);           // every label its own root
        end else if (state == st_find && roots_found && a_q != b_q) begin
            parent[hi_root] <= lo_root;             // links only point downward
        end else if (state == st_flat) begin
            parent[idx_q] <= parent[parent[idx_q]]; // lower labels already flat
        end
    end

    // one link per cycle on each side
    always_ff @(posedge clk) begin
        if (state == st_load) begin
            a_q <= pair_hi[rd_ptr];
            b_q <= pair_lo[rd_ptr];
        end else if (state == st_find) begin
            a_q <= parent[a_q];
            b_q <= parent[b_q];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            idx_q      <= '0;
            resolved_q <= 1'b0;
        end else begin
            resolved_q <= 1'b0;
            if (frame_start_i)
                wr_ptr <= '0;
            else if (eq_i.push_valid)
                wr_ptr <= wr_ptr + 1'b1;
            case (state)
                st_idle: begin
                    rd_ptr <= '0;
                    if (eq_i.resolve_start)
                        state <= st_load;
                end
                st_load: begin
                    if (rd_ptr == wr_ptr) begin     // queue drained
                        idx_q <= label_t'(1);
                        state <= st_flat;
                    end else begin
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= st_find;
                    end
                end
                st_find: begin
                    if (roots_found)
                        state <= st_load;
                end
                default: begin
                    idx_q <= idx_q + 1'b1;
                    if (idx_q == label_t'(`CCL_MAX_LABELS - 1)) begin
                        resolved_q <= 1'b1;
                        state      <= st_idle;
                    end
                end
            endcase
        end
    end

    // pairs arrive ordered and never hold background
    a_push_order: assert property (@(posedge clk) disable iff (rst)
        eq_i.push_valid |-> (eq_i.push_hi > eq_i.push_lo) && (eq_i.push_lo != '0));

endmodule

//--- hdl/feature_store.sv
// per-label area and bounding box, filled by the first pass and folded by the report
`timescale 1ns/1ps
`include "ccl_macros.svh"

module feature_store import ccl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     frame_start_i,
    feature_if.store feat_i
);
    area_t   area [`CCL_MAX_LABELS];
    xcoord_t xmin [`CCL_MAX_LABELS];
    xcoord_t xmax [`CCL_MAX_LABELS];
    ycoord_t ymin [`CCL_MAX_LABELS];
    ycoord_t ymax [`CCL_MAX_LABELS];
    label_t  ul;
    label_t  ms;
    label_t  md;
    logic    fresh;

    assign ul    = feat_i.upd_label;
    assign ms    = feat_i.merge_src;
    assign md    = feat_i.merge_dst;
    assign fresh = (area[ul] == '0);       // first pixel of this label

    assign feat_i.rd_area = area[feat_i.rd_label];
    assign feat_i.rd_xmin = xmin[feat_i.rd_label];
    assign feat_i.rd_xmax = xmax[feat_i.rd_label];
    assign feat_i.rd_ymin = ymin[feat_i.rd_label];
    assign feat_i.rd_ymax = ymax[feat_i.rd_label];

    // a zero area also marks a label as unused
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CCL_MAX_LABELS; i++)
                area[i] <= '0;
        end else if (frame_start_i) begin
            for (int i = 0; i < `CCL_MAX_LABELS; i++)
                area[i] <= '0;
        end else if (feat_i.upd_valid) begin
            area[ul] <= area[ul] + 1'b1;
        end else if (feat_i.merge_valid) begin
            area[md] <= area[md] + area[ms];
        end
    end

    always_ff @(posedge clk) begin
        if (feat_i.upd_valid) begin
            if (fresh || feat_i.upd_x < xmin[ul])
                xmin[ul] <= feat_i.upd_x;
            if (fresh || feat_i.upd_x > xmax[ul])
                xmax[ul] <= feat_i.upd_x;
            if (fresh)
                ymin[ul] <= feat_i.upd_y;  // raster order, first row is the top
            ymax[ul] <= feat_i.upd_y;
        end else if (feat_i.merge_valid) begin
            if (xmin[ms] < xmin[md])
                xmin[md] <= xmin[ms];
            if (xmax[ms] > xmax[md])
                xmax[md] <= xmax[ms];
            if (ymin[ms] < ymin[md])
                ymin[md] <= ymin[ms];
            if (ymax[ms] > ymax[md])
                ymax[md] <= ymax[ms];
        end
    end

    // neither pass may touch the background entry
    a_upd_no_bg: assert property (@(posedge clk) disable iff (rst)
        feat_i.upd_valid |-> ul != '0);
    a_merge_no_bg: assert property (@(posedge clk) disable iff (rst)
        feat_i.merge_valid |-> (ms != '0) && (md != '0));

endmodule

//--- hdl/component_report.sv
// second pass, folds labels into their roots after resolve and streams one result per root
`timescale 1ns/1ps
`include "ccl_macros.svh"

module component_report import ccl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        frame_end_i,
    feature_if.merge_rd feat_o,
    equiv_if.query      eq_o,
    output logic        busy_o,
    output logic        res_valid_o,
    output label_t      res_label_o,
    output area_t       res_area_o,
    output xcoord_t     res_xmin_o,
    output xcoord_t     res_xmax_o,
    output ycoord_t     res_ymin_o,
    output ycoord_t     res_ymax_o,
    output logic        frame_done_o
);
    report_phase_t phase;
    label_t        idx_q;
    logic          used;       // label was issued this frame
    logic          is_root;
    logic          last;

    assign used    = (feat_o.rd_area != '0);
    assign is_root = (eq_o.q_root == idx_q);
    assign last    = !used || (idx_q == label_t'(`CCL_MAX_LABELS - 1));

    assign eq_o.q_label       = idx_q;
    assign eq_o.resolve_start = (phase == rp_idle) && frame_end_i;
    assign feat_o.rd_label    = idx_q;
    assign feat_o.merge_valid = (phase == rp_fold) && used && !is_root;
    assign feat_o.merge_src   = idx_q;
    assign feat_o.merge_dst   = eq_o.q_root;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase        <= rp_idle;
            idx_q        <= '0;
            busy_o       <= 1'b0;
            res_valid_o  <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            res_valid_o  <= 1'b0;
            frame_done_o <= 1'b0;
            case (phase)
                rp_idle: begin
                    if (frame_end_i) begin
                        busy_o <= 1'b1;
                        phase  <= rp_wait_resolve;
                    end
                end
                rp_wait_resolve: begin
                    idx_q <= label_t'(1);
                    if (eq_o.resolved)
                        phase <= rp_fold;
                end
                rp_fold: begin
                    idx_q <= last ? label_t'(1) : idx_q + 1'b1;
                    if (last)
                        phase <= rp_emit;
                end
                rp_emit: begin
                    res_valid_o <= used && is_root;
                    idx_q       <= idx_q + 1'b1;
                    if (last) begin
                        frame_done_o <= 1'b1;   // lands with the last result
                        phase        <= rp_done;
                    end
                end
                default: begin
                    busy_o <= 1'b0;
                    phase  <= rp_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        res_label_o <= idx_q;
        res_area_o  <= feat_o.rd_area;
        res_xmin_o  <= feat_o.rd_xmin;
        res_xmax_o  <= feat_o.rd_xmax;
        res_ymin_o  <= feat_o.rd_ymin;
        res_ymax_o  <= feat_o.rd_ymax;
    end

    // front end holds frames back until the report has finished
    a_frame_gap: assert property (@(posedge clk) disable iff (rst)
        frame_end_i |-> phase == rp_idle);

endmodule

//--- hdl/ccl_top.sv
// top level of the two-pass labeling core, video in and one result per component out
`timescale 1ns/1ps

module ccl_top import ccl_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    vsync_i,
    input  logic    href_i,
    input  logic    pix_i,
    output logic    busy_o,
    output logic    res_valid_o,
    output label_t  res_label_o,
    output area_t   res_area_o,
    output xcoord_t res_xmin_o,
    output xcoord_t res_xmax_o,
    output ycoord_t res_ymin_o,
    output ycoord_t res_ymax_o,
    output logic    frame_done_o
);
    pix_if     pix_bus ();
    feature_if feat_bus ();
    equiv_if   eq_bus ();

    pixel_frontend u_frontend (
        .clk     (clk),
        .rst     (rst),
        .vsync_i (vsync_i),
        .href_i  (href_i),
        .pix_i   (pix_i),
        .busy_i  (busy_o),
        .pix_o   (pix_bus.src)
    );

    label_assign u_label (
        .clk    (clk),
        .rst    (rst),
        .pix_i  (pix_bus.dst),
        .feat_o (feat_bus.pix_wr),
        .eq_o   (eq_bus.push)
    );

    equiv_table u_equiv (
        .clk           (clk),
        .rst           (rst),
        .frame_start_i (pix_bus.frame_start),
        .eq_i          (eq_bus.tbl)
    );

    feature_store u_features (
        .clk           (clk),
        .rst           (rst),
        .frame_start_i (pix_bus.frame_start),
        .feat_i        (feat_bus.store)
    );

    component_report u_report (
        .clk          (clk),
        .rst          (rst),
        .frame_end_i  (pix_bus.frame_end),
        .feat_o       (feat_bus.merge_rd),
        .eq_o         (eq_bus.query),
        .busy_o       (busy_o),
        .res_valid_o  (res_valid_o),
        .res_label_o  (res_label_o),
        .res_area_o   (res_area_o),
        .res_xmin_o   (res_xmin_o),
        .res_xmax_o   (res_xmax_o),
        .res_ymin_o   (res_ymin_o),
        .res_ymax_o   (res_ymax_o),
        .frame_done_o (frame_done_o)
    );

endmodule

//--- sim/tb_ccl.sv
// testbench for the labeling core, drives binary frames and checks every reported component
`timescale 1ns/1ps
`include "ccl_macros.svh"

module tb_ccl import ccl_pkg::*; ();
    localparam int W            = `CCL_IMG_W;
    localparam int H            = `CCL_IMG_H;
    localparam int N_FRAMES     = 28;
    localparam int FRAME_CYCLES = W * H + 2 * H + 6 + 3 * W * H;  // pixels, blanking, resolve
    localparam int CYCLE_LIMIT  = 2 * N_FRAMES * FRAME_CYCLES;

    typedef struct packed {
        int label;
        int area;
        int xmin;
        int xmax;
        int ymin;
        int ymax;
    } comp_t;

    logic    clk;
    logic    rst;
    logic    vsync_i;
    logic    href_i;
    logic    pix_i;
    logic    busy_o;
    logic    res_valid_o;
    label_t  res_label_o;
    area_t   res_area_o;
    xcoord_t res_xmin_o;
    xcoord_t res_xmax_o;
    ycoord_t res_ymin_o;
    ycoord_t res_ymax_o;
    logic    frame_done_o;

    bit          img  [H][W];
    bit          seen [H][W];   // flood fill marks
    comp_t       exp_q [$];
    comp_t       got_q [$];
    int          done_cnt  = 0;
    int          cycles    = 0;
    int          test_errs = 0;
    int          errors    = 0;
    int          tests     = 0;
    int          failed    = 0;
    logic [31:0] rng       = 32'hca8bdcdd;

    ccl_top UUT (
        .clk          (clk),
        .rst          (rst),
        .vsync_i      (vsync_i),
        .href_i       (href_i),
        .pix_i        (pix_i),
        .busy_o       (busy_o),
        .res_valid_o  (res_valid_o),
        .res_label_o  (res_label_o),
        .res_area_o   (res_area_o),
        .res_xmin_o   (res_xmin_o),
        .res_xmax_o   (res_xmax_o),
        .res_ymin_o   (res_ymin_o),
        .res_ymax_o   (res_ymax_o),
        .frame_done_o (frame_done_o)
    );

    always #2 clk = ~clk;

    // results stream without stall, taken at every falling edge
    always @(negedge clk) begin
        comp_t c;
        if (res_valid_o) begin
            c.label = int'(res_label_o);
            c.area  = int'(res_area_o);
            c.xmin  = int'(res_xmin_o);
            c.xmax  = int'(res_xmax_o);
            c.ymin  = int'(res_ymin_o);
            c.ymax  = int'(res_ymax_o);
            got_q.push_back(c);
        end
        if (frame_done_o)
            done_cnt++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: no frame_done_o within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_value(input string sig, input int got, input int exp);
        assert (got == exp) else begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic clear_image();
        for (int y = 0; y < H; y++)
            for (int x = 0; x < W; x++)
                img[y][x] = 1'b0;
    endtask

    task automatic fill_rect(input int x0, input int x1, input int y0, input int y1);
        for (int y = y0; y <= y1; y++)
            for (int x = x0; x <= x1; x++)
                img[y][x] = 1'b1;
    endtask

    // 4-connected flood fill in raster order, root label = labels opened up to the first pixel
    function automatic void build_expected();
        int    sx [$];
        int    sy [$];
        int    issued;
        int    cx;
        int    cy;
        int    nx;
        int    ny;
        comp_t c;
        exp_q.delete();
        issued = 0;
        for (int y = 0; y < H; y++)
            for (int x = 0; x < W; x++)
                seen[y][x] = 1'b0;
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                if (img[y][x] && (y == 0 || !img[y-1][x]) && (x == 0 || !img[y][x-1]))
                    issued++;   // no foreground above or left
                if (img[y][x] && !seen[y][x]) begin
                    c = '{issued, 0, x, x, y, y};
                    seen[y][x] = 1'b1;
                    sx.push_back(x);
                    sy.push_back(y);
                    while (sx.size() > 0) begin
                        cx = sx.pop_back();
                        cy = sy.pop_back();
                        c.area++;
                        if (cx < c.xmin)
                            c.xmin = cx;
                        if (cx > c.xmax)
                            c.xmax = cx;
                        if (cy < c.ymin)
                            c.ymin = cy;
                        if (cy > c.ymax)
                            c.ymax = cy;
                        for (int d = 0; d < 4; d++) begin
                            nx = cx + ((d == 0) ? 1 : (d == 1) ? -1 : 0);
                            ny = cy + ((d == 2) ? 1 : (d == 3) ? -1 : 0);
                            if (nx >= 0 && nx < W && ny >= 0 && ny < H) begin
                                if (img[ny][nx] && !seen[ny][nx]) begin
                                    seen[ny][nx] = 1'b1;
                                    sx.push_back(nx);
                                    sy.push_back(ny);
                                end
                            end
                        end
                    end
                    exp_q.push_back(c);
                end
            end
        end
    endfunction

    // vsync around the frame, two blank cycles after each line
    task automatic drive_frame();
        @(negedge clk);
        vsync_i = 1'b1;
        repeat (2) @(negedge clk);
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                href_i = 1'b1;
                pix_i  = img[y][x];
                @(negedge clk);
            end
            href_i = 1'b0;
            pix_i  = 1'b0;
            repeat (2) @(negedge clk);
        end
        vsync_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_done(input int target);
        while (done_cnt < target)
            @(negedge clk);
    endtask

    task automatic compare_results();
        comp_t g;
        comp_t e;
        check_value("res_valid_o pulse count", got_q.size(), exp_q.size());
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            g = got_q[i];
            e = exp_q[i];
            check_value("res_label_o", g.label, e.label);
            check_value("res_area_o", g.area, e.area);
            check_value("res_xmin_o", g.xmin, e.xmin);
            check_value("res_xmax_o", g.xmax, e.xmax);
            check_value("res_ymin_o", g.ymin, e.ymin);
            check_value("res_ymax_o", g.ymax, e.ymax);
        end
        got_q.delete();
    endtask

    task automatic play_frame();
        int target;
        target = done_cnt + 1;
        drive_frame();
        wait_done(target);
        compare_results();
    endtask

    task automatic run_frame();
        build_expected();
        play_frame();
    endtask

    task automatic expect_one(input int area, input int x0, input int x1,
                              input int y0, input int y1);
        comp_t c;
        c = '{1, area, x0, x1, y0, y1};
        exp_q.delete();
        exp_q.push_back(c);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_errs == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, test_errs);
            failed++;
        end
        errors += test_errs;
        test_errs = 0;
    endtask

    task automatic test_rect();
        clear_image();
        fill_rect(3, 10, 2, 6);
        expect_one(40, 3, 10, 2, 6);
        play_frame();
        finish_test("filled rectangle");
    endtask

    task automatic test_blobs();
        clear_image();
        fill_rect(1, 4, 1, 3);
        fill_rect(8, 8, 0, 0);
        fill_rect(10, 13, 5, 5);    // L shape
        fill_rect(13, 13, 6, 9);
        fill_rect(15, 15, 10, 15);
        fill_rect(0, 0, 15, 15);
        fill_rect(2, 7, 12, 12);
        run_frame();
        finish_test("separate blobs");
    endtask

    // both shapes open several labels that only meet further down
    task automatic test_shapes();
        clear_image();
        fill_rect(2, 3, 1, 7);
        fill_rect(8, 9, 1, 7);
        fill_rect(2, 9, 8, 9);
        expect_one(44, 2, 9, 1, 9);
        play_frame();
        clear_image();
        for (int y = 0; y <= 6; y++)
            fill_rect(12 - 2 * y, 15 - 2 * y, y, y);
        expect_one(28, 0, 15, 0, 6);
        play_frame();
        finish_test("U shape and staircase");
    endtask

    task automatic test_empty_busy();
        int target;
        clear_image();
        run_frame();
        fill_rect(1, 5, 1, 5);
        fill_rect(9, 14, 9, 12);
        build_expected();
        target = done_cnt + 1;
        drive_frame();
        repeat (4) @(negedge clk);
        assert (busy_o) else begin
            $display("busy_o was low when the second frame started at %0t", $time);
            test_errs++;
        end
        clear_image();
        fill_rect(0, 15, 0, 15);    // must be ignored
        drive_frame();
        wait_done(target);
        compare_results();
        repeat (3 * W * H) @(negedge clk);   // longer than any resolve and report
        assert (done_cnt == target && got_q.size() == 0) else begin
            $display("a frame sent while busy produced results at %0t", $time);
            test_errs++;
        end
        clear_image();
        fill_rect(6, 6, 3, 11);
        fill_rect(0, 2, 14, 15);
        run_frame();
        finish_test("empty and busy frames");
    endtask

    task automatic test_random();
        int dens;
        for (int f = 0; f < 20; f++) begin
            dens = 15 + 15 * (f % 5);   // percent foreground
            for (int y = 0; y < H; y++) begin
                for (int x = 0; x < W; x++) begin
                    if (f == 9)
                        img[y][x] = ((x + y) % 2 == 0);   // checkerboard, full label table
                    else
                        img[y][x] = (next_random() % 100) < dens;
                end
            end
            run_frame();
        end
        finish_test("random frames");
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        vsync_i = 1'b0;
        href_i  = 1'b0;
        pix_i   = 1'b0;
        repeat (5) @(negedge clk);
        check_value("busy_o", busy_o, 0);
        check_value("res_valid_o", res_valid_o, 0);
        check_value("frame_done_o", frame_done_o, 0);
        finish_test("reset");
        rst = 1'b0;
        repeat (2) @(negedge clk);
        test_rect();
        test_blobs();
        test_shapes();
        test_empty_busy();
        test_random();
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/ccl_pkg.sv
hdl/ccl_ifs.sv
hdl/pixel_frontend.sv
hdl/label_assign.sv
hdl/equiv_table.sv
hdl/feature_store.sv
hdl/component_report.sv
hdl/ccl_top.sv
sim/tb_ccl.sv

//--- run.sh
#!/bin/sh
# build the labeling testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_ccl -f compile.f -o tb_ccl || exit 1
./obj_dir/tb_ccl | tee /dev/stderr | grep -q "^RESULT: PASS$" && exit 0 || exit 1
